// File: core_port_router.sv
module core_port_router
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  run_en,
    input  logic                  fetch_ready,
    input  logic                  ex_stalled,
    input  router_pkg::core_req_t core_req,
    input  logic                  cache_ready,
    input  router_pkg::data_t     cache_rdata,
    input  logic                  rd_addr_ready,
    input  logic                  rd_data_valid,
    input  router_pkg::data_t     rd_data,
    input  logic                  wr_ready,
    input  logic                  wr_complete,
    output logic                  core_ready,
    output router_pkg::data_t     core_rdata,
    output logic                  fetch_en,
    output router_pkg::core_req_t cache_req,
    output logic                  exit_wr_en,
    output router_pkg::data_t     exit_wr_data,
    output router_pkg::addr_t     rd_addr,
    output logic                  rd_addr_valid,
    output logic                  rd_data_ready,
    output router_pkg::addr_t     wr_addr,
    output router_pkg::data_t     wr_data,
    output router_pkg::strb_t     wr_strb,
    output logic                  wr_valid
);
    import router_pkg::*;

    // Steering to sequencer
    logic      peri_req;
    peri_cmd_t peri_cmd;
    logic      seq_idle;
    logic      fetch_hold;
    logic      data_hold;
    logic      resp_valid;
    data_t     resp_data;

    // Sequencer to bus master
    logic      start;
    peri_cmd_t cmd;
    logic      done;
    data_t     done_data;

    request_steer u_request_steer (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .run_en       (run_en),
        .fetch_ready  (fetch_ready),
        .ex_stalled   (ex_stalled),
        .core_req     (core_req),
        .cache_ready  (cache_ready),
        .cache_rdata  (cache_rdata),
        .seq_idle     (seq_idle),
        .fetch_hold   (fetch_hold),
        .data_hold    (data_hold),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .core_ready   (core_ready),
        .core_rdata   (core_rdata),
        .fetch_en     (fetch_en),
        .cache_req    (cache_req),
        .exit_wr_en   (exit_wr_en),
        .exit_wr_data (exit_wr_data),
        .peri_req     (peri_req),
        .peri_cmd     (peri_cmd)
    );

    peri_access_seq u_peri_access_seq (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .peri_req   (peri_req),
        .peri_cmd   (peri_cmd),
        .done       (done),
        .rd_data    (done_data),
        .seq_idle   (seq_idle),
        .fetch_hold (fetch_hold),
        .data_hold  (data_hold),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .start      (start),
        .cmd        (cmd)
    );

    peri_bus_master u_peri_bus_master (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .start         (start),
        .cmd           (cmd),
        .rd_addr_ready (rd_addr_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data_in    (rd_data),
        .wr_ready      (wr_ready),
        .wr_complete   (wr_complete),
        .done          (done),
        .rd_data       (done_data),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_data_ready (rd_data_ready),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .wr_valid      (wr_valid)
    );

endmodule

// File: peri_access_seq.sv
module peri_access_seq
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  peri_req,
    input  router_pkg::peri_cmd_t peri_cmd,
    input  logic                  done,
    input  router_pkg::data_t     rd_data,
    output logic                  seq_idle,
    output logic                  fetch_hold,
    output logic                  data_hold,
    output logic                  resp_valid,
    output router_pkg::data_t     resp_data,
    output logic                  start,
    output router_pkg::peri_cmd_t cmd
);
    import router_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    ////////////////////
    // Sequencer FSM
    ////////////////////
    always_comb
    begin
        state_nxt = state;
        case (state)
            SEQ_IDLE:
            begin
                if (peri_req)
                    state_nxt = SEQ_ISSUE;
            end
            SEQ_ISSUE:
            begin
                state_nxt = SEQ_WAIT;
            end
            SEQ_WAIT:
            begin
                if (done)
                    state_nxt = SEQ_RESP;
            end
            SEQ_RESP:
            begin
                state_nxt = SEQ_IDLE;
            end
            default:
            begin
                state_nxt = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
            state <= SEQ_IDLE;
        else
            state <= state_nxt;
    end

    // Command captured at the request edge
    always_ff @(posedge CLK)
    begin
        if (state == SEQ_IDLE && peri_req)
            cmd <= peri_cmd;
    end

    // Result held for the RESP cycle
    always_ff @(posedge CLK)
    begin
        if (state == SEQ_WAIT && done)
            resp_data <= rd_data;
    end

    ////////////////////
    // Core holds
    ////////////////////
    assign seq_idle   = (state == SEQ_IDLE);
    assign start      = (state == SEQ_ISSUE);
    assign fetch_hold = (state == SEQ_ISSUE) || (state == SEQ_WAIT);
    assign data_hold  = (state == SEQ_ISSUE) || (state == SEQ_WAIT);
    assign resp_valid = (state == SEQ_RESP);

    // Steering must not launch a second access while one is open
    a_req_when_idle: assert property (@(posedge CLK) disable iff (!rst_n)
        peri_req |-> state == SEQ_IDLE);

    // Bus master answers only an issued command
    a_done_when_waiting: assert property (@(posedge CLK) disable iff (!rst_n)
        done |-> state == SEQ_WAIT);

endmodule

// File: peri_bus_master.sv
module peri_bus_master
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  start,
    input  router_pkg::peri_cmd_t cmd,
    input  logic                  rd_addr_ready,
    input  logic                  rd_data_valid,
    input  router_pkg::data_t     rd_data_in,
    input  logic                  wr_ready,
    input  logic                  wr_complete,
    output logic                  done,
    output router_pkg::data_t     rd_data,
    output router_pkg::addr_t     rd_addr,
    output logic                  rd_addr_valid,
    output logic                  rd_data_ready,
    output router_pkg::addr_t     wr_addr,
    output router_pkg::data_t     wr_data,
    output router_pkg::strb_t     wr_strb,
    output logic                  wr_valid
);
    import router_pkg::*;

    bus_state_e state;
    bus_state_e state_nxt;
    peri_cmd_t  cmd_q;

    ////////////////////
    // Bus FSM
    ////////////////////
    always_comb
    begin
        state_nxt = state;
        case (state)
            BUS_IDLE:
            begin
                if (start)
                    state_nxt = BUS_ADDR;
            end
            BUS_ADDR:
            begin
                // Write sends address and data together
                if (cmd_q.write)
                begin
                    if (wr_ready)
                        state_nxt = BUS_WCOMP;
                end
                else if (rd_addr_ready)
                begin
                    state_nxt = BUS_RDATA;
                end
            end
            BUS_RDATA:
            begin
                if (rd_data_valid)
                    state_nxt = BUS_DONE;
            end
            BUS_WCOMP:
            begin
                if (wr_complete)
                    state_nxt = BUS_DONE;
            end
            BUS_DONE:
            begin
                state_nxt = BUS_IDLE;
            end
            default:
            begin
                state_nxt = BUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
            state <= BUS_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge CLK)
    begin
        if (state == BUS_IDLE && start)
            cmd_q <= cmd;
    end

    // Read beat
    always_ff @(posedge CLK)
    begin
        if (state == BUS_RDATA && rd_data_valid)
            rd_data <= rd_data_in;
    end

    ////////////////////
    // Channel outputs
    ////////////////////
    assign rd_addr_valid = (state == BUS_ADDR) && !cmd_q.write;
    assign wr_valid      = (state == BUS_ADDR) && cmd_q.write;
    assign rd_data_ready = (state == BUS_RDATA);
    assign done          = (state == BUS_DONE);

    assign rd_addr = cmd_q.addr;
    assign wr_addr = cmd_q.addr;
    assign wr_data = cmd_q.wdata;
    assign wr_strb = cmd_q.strb;

    // Valid and payload hold until the slave takes them
    a_rd_addr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_addr));

    a_wr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable({wr_addr, wr_data, wr_strb}));

endmodule

// File: request_steer.sv
`include "router_defines.svh"

module request_steer
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  run_en,
    input  logic                  fetch_ready,
    input  logic                  ex_stalled,
    input  router_pkg::core_req_t core_req,
    input  logic                  cache_ready,
    input  router_pkg::data_t     cache_rdata,
    input  logic                  seq_idle,
    input  logic                  fetch_hold,
    input  logic                  data_hold,
    input  logic                  resp_valid,
    input  router_pkg::data_t     resp_data,
    output logic                  core_ready,
    output router_pkg::data_t     core_rdata,
    output logic                  fetch_en,
    output router_pkg::core_req_t cache_req,
    output logic                  exit_wr_en,
    output router_pkg::data_t     exit_wr_data,
    output logic                  peri_req,
    output router_pkg::peri_cmd_t peri_cmd
);
    import router_pkg::*;

    mem_ctrl_t ctrl;
    logic      req_active;
    logic      is_exit;
    logic      is_peri;
    logic      is_cache;
    logic      exit_fire;

    ////////////////////
    // Address decode
    ////////////////////
    assign ctrl       = core_req.ctrl;
    assign req_active = (ctrl != `CTRL_IDLE);
    assign is_exit    = (core_req.addr == `EXIT_ADDR);
    assign is_peri    = (core_req.addr >= `PERI_BASE);
    assign is_cache   = !is_peri && !is_exit;

    // Cache sees only its own region
    always_comb
    begin
        cache_req = core_req;
        if (!is_cache)
            cache_req.ctrl = `CTRL_IDLE;
    end

    assign core_ready = cache_ready && !data_hold;

    // Peripheral result replaces cache data for one cycle
    assign core_rdata = resp_valid ? resp_data : cache_rdata;

    assign fetch_en = fetch_ready && !ex_stalled && run_en && !fetch_hold;

    ////////////////////
    // Exit port
    ////////////////////
    assign exit_fire = is_exit && (ctrl == `CTRL_WRITE) && cache_ready && fetch_ready && run_en;

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
            exit_wr_en <= 1'b0;
        else
            exit_wr_en <= exit_fire;
    end

    always_ff @(posedge CLK)
    begin
        if (exit_fire)
            exit_wr_data <= core_req.wdata;
    end

    ////////////////////
    // Peripheral launch
    ////////////////////
    // Only while nothing else is in flight
    assign peri_req = is_peri && req_active && cache_ready && fetch_ready && seq_idle;

    // Flush falls through as a read here
    always_comb
    begin
        peri_cmd.write = (ctrl == `CTRL_WRITE);
        peri_cmd.addr  = core_req.addr;
        peri_cmd.wdata = core_req.wdata;
        peri_cmd.strb  = core_req.strb;
    end

    // Every strobe comes from an exit write the core actually handed off
    a_exit_per_request: assert property (@(posedge CLK) disable iff (!rst_n)
        exit_wr_en |-> $past(core_ready));

endmodule

// File: router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

////////////////////
// Bus widths
////////////////////
`define ADDR_W      32
`define DATA_W      32
`define STRB_W      4

////////////////////
// Address map
////////////////////
// Single word that feeds the exit port
`define EXIT_ADDR   32'h0001_0150
// Everything at or above this goes to the peripheral bus
`define PERI_BASE   32'h1000_0000

// Core control codes
`define CTRL_IDLE   2'd0
`define CTRL_READ   2'd1
`define CTRL_WRITE  2'd2
`define CTRL_FLUSH  2'd3

`endif

// File: router_pkg.sv
`include "router_defines.svh"

package router_pkg;

    ////////////////////
    // Plain vectors
    ////////////////////
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`STRB_W-1:0] strb_t;

    // Idle, read, write, flush
    typedef logic [1:0] mem_ctrl_t;

    ////////////////////
    // Request structs
    ////////////////////
    // Core load/store request, also the gated cache request
    typedef struct packed {
        mem_ctrl_t ctrl;
        addr_t     addr;
        data_t     wdata;
        strb_t     strb;
    } core_req_t;

    // One peripheral bus transaction
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } peri_cmd_t;

    ////////////////////
    // State machines
    ////////////////////
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT, SEQ_RESP} seq_state_e;

    typedef enum logic [2:0] {BUS_IDLE, BUS_ADDR, BUS_RDATA, BUS_WCOMP, BUS_DONE} bus_state_e;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_core_port_router -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

// File: tb.f
+incdir+.
router_pkg.sv
request_steer.sv
peri_access_seq.sv
peri_bus_master.sv
core_port_router.sv
tb_core_port_router.sv

// File: tb_core_port_router.sv
`include "router_defines.svh"

module tb_core_port_router;
    timeunit 1ns;
    timeprecision 1ps;
    import router_pkg::*;

    localparam int NUM_VEC = 15;
    localparam int TIMEOUT = 60;

    // One row of the stimulus table
    typedef struct packed {
        mem_ctrl_t ctrl;
        addr_t     addr;
        data_t     wdata;
        strb_t     strb;
        logic      run;
        data_t     rsp;
        data_t     exp;
        logic      exp_exit;
    } vec_t;

    // ctrl, addr, wdata, strb, run_en, responder value, expected data, exit strobe
    vec_t vectors [NUM_VEC] = '{
        '{`CTRL_READ,  32'h00001000, 32'h00000000, 4'h0, 1'b1, 32'hcafe0001, 32'hcafe0001, 1'b0},
        '{`CTRL_WRITE, 32'h00002004, 32'h12345678, 4'hf, 1'b1, 32'h00000000, 32'h00000000, 1'b0},
        '{`CTRL_WRITE, `EXIT_ADDR,   32'h0000002a, 4'hf, 1'b1, 32'h00000000, 32'h0000002a, 1'b1},
        '{`CTRL_READ,  `EXIT_ADDR,   32'h00000000, 4'h0, 1'b1, 32'h00000000, 32'h00000000, 1'b0},
        '{`CTRL_WRITE, `EXIT_ADDR,   32'h00000063, 4'hf, 1'b0, 32'h00000000, 32'h00000063, 1'b0},
        '{`CTRL_WRITE, 32'h10000010, 32'ha5a50102, 4'h3, 1'b1, 32'h00000000, 32'h00000000, 1'b0},
        '{`CTRL_READ,  32'h10000020, 32'h00000000, 4'h0, 1'b1, 32'h3c3c7e7e, 32'h3c3c7e7e, 1'b0},
        '{`CTRL_FLUSH, 32'h10000030, 32'h00000000, 4'h0, 1'b1, 32'h0badf00d, 32'h0badf00d, 1'b0},
        '{`CTRL_READ,  32'hfffffffc, 32'h00000000, 4'h0, 1'b1, 32'h13579bdf, 32'h13579bdf, 1'b0},
        '{`CTRL_READ,  32'h00000ff0, 32'h00000000, 4'h0, 1'b1, 32'h2468ace0, 32'h2468ace0, 1'b0},
        '{`CTRL_WRITE, `EXIT_ADDR,   32'hffff0000, 4'hf, 1'b1, 32'h00000000, 32'hffff0000, 1'b1},
        '{`CTRL_WRITE, 32'h20000000, 32'h87654321, 4'h8, 1'b1, 32'h00000000, 32'h00000000, 1'b0},
        '{`CTRL_WRITE, `EXIT_ADDR,   32'h00000001, 4'h1, 1'b1, 32'h00000000, 32'h00000001, 1'b1},
        '{`CTRL_WRITE, 32'h0ffffffc, 32'h0f0f0f0f, 4'hc, 1'b1, 32'h00000000, 32'h00000000, 1'b0},
        '{`CTRL_READ,  32'h10000100, 32'h00000000, 4'h0, 1'b1, 32'h5a5a5a5a, 32'h5a5a5a5a, 1'b0}
    };

    logic      CLK = 1'b0;
    logic      rst_n;
    logic      run_en;
    logic      fetch_ready;
    logic      ex_stalled;
    core_req_t core_req;
    logic      cache_ready;
    data_t     cache_rdata;
    data_t     rd_data;
    logic      rd_addr_ready = 1'b0;
    logic      rd_data_valid = 1'b0;
    logic      wr_ready = 1'b0;
    logic      wr_complete = 1'b0;
    logic      core_ready;
    data_t     core_rdata;
    logic      fetch_en;
    core_req_t cache_req;
    logic      exit_wr_en;
    data_t     exit_wr_data;
    addr_t     rd_addr;
    logic      rd_addr_valid;
    logic      rd_data_ready;
    addr_t     wr_addr;
    data_t     wr_data;
    strb_t     wr_strb;
    logic      wr_valid;

    int   mismatches = 0;
    int   timeouts = 0;
    int   strobes = 0;
    int   peri_beats = 0;
    int   comp_wait = 0;
    logic wr_seen = 1'b0;

    always #4 CLK = ~CLK;

    core_port_router u_core_port_router (.*);

    task automatic check(input logic [69:0] actual, input logic [69:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            mismatches++;
        end
    endtask

    function automatic logic in_cache_region(input addr_t addr);
        return (addr < `PERI_BASE) && (addr != `EXIT_ADDR);
    endfunction

    // Cache sees the request only inside its own region
    function automatic core_req_t expected_cache_req(input vec_t v);
        core_req_t req;
        req = '{v.ctrl, v.addr, v.wdata, v.strb};
        if (!in_cache_region(v.addr))
            req.ctrl = `CTRL_IDLE;
        return req;
    endfunction

    task automatic drive_request(input vec_t v);
        core_req = '{v.ctrl, v.addr, v.wdata, v.strb};
        run_en   = v.run;
        rd_data  = v.rsp;
        // Wrong data on the unused source catches a bad return mux
        cache_rdata = in_cache_region(v.addr) ? v.rsp : ~v.rsp;
    endtask

    ////////////////////
    // Peripheral model
    ////////////////////
    initial
    begin
        void'($urandom(32'h33c68596));
        forever
        begin
            @(negedge CLK);
            if (!rst_n)
            begin
                rd_addr_ready = 1'b0;
                rd_data_valid = 1'b0;
                wr_ready      = 1'b0;
                wr_complete   = 1'b0;
                comp_wait     = 0;
                wr_seen       = 1'b0;
            end
            else
            begin
                rd_addr_ready = ($urandom % 2) == 0;
                wr_ready      = ($urandom % 3) == 0;
                // Data beat is held until the master drops ready after taking it
                if (rd_data_valid && !rd_data_ready)
                begin
                    rd_data_valid = 1'b0;
                    peri_beats++;
                end
                else if (!rd_data_valid && rd_data_ready)
                begin
                    rd_data_valid = ($urandom % 2) == 0;
                end
                wr_complete = 1'b0;
                if (comp_wait > 0)
                begin
                    comp_wait--;
                    wr_complete = (comp_wait == 0);
                end
                // Write valid gone means the address/data beat was taken
                if (wr_seen && !wr_valid)
                begin
                    comp_wait = 1 + int'($urandom % 3);
                    peri_beats++;
                end
                wr_seen = wr_valid;
            end
        end
    end

    // Exit strobe monitor
    always @(negedge CLK)
    begin
        if (rst_n && exit_wr_en)
            strobes++;
    end

    ////////////////////
    // Access sequences
    ////////////////////
    task automatic local_access(input vec_t v);
        @(negedge CLK);
        drive_request(v);
        #1;
        check(70'(cache_req), 70'(expected_cache_req(v)), "cache_req");
        check(70'(fetch_en), 70'(v.run), "fetch_en");
        check(70'(core_ready), 70'(1), "core_ready on local access");
        if (v.ctrl == `CTRL_READ && in_cache_region(v.addr))
            check(70'(core_rdata), 70'(v.exp), "core_rdata from cache");
        @(negedge CLK);
        core_req = '0;
        #1;
        check(70'(exit_wr_en), 70'(v.exp_exit), "exit_wr_en one cycle later");
        if (v.exp_exit)
            check(70'(exit_wr_data), 70'(v.exp), "exit_wr_data");
    endtask

    task automatic peri_access(input vec_t v);
        int   waited;
        logic finished;
        logic comp_seen;
        logic is_write;
        waited    = 0;
        finished  = 1'b0;
        comp_seen = 1'b0;
        is_write  = (v.ctrl == `CTRL_WRITE);
        @(negedge CLK);
        drive_request(v);
        #1;
        check(70'(cache_req), 70'(expected_cache_req(v)), "cache_req on peripheral access");
        check(70'(core_ready), 70'(1), "core_ready before peripheral access");
        @(negedge CLK);
        core_req = '0;
        // Core stays held until core_ready comes back
        while (!finished && waited < TIMEOUT)
        begin
            #1;
            if (core_ready)
            begin
                finished = 1'b1;
            end
            else
            begin
                check(70'(fetch_en), 70'(0), "fetch_en during peripheral access");
                if (wr_valid || rd_addr_valid)
                    check(70'(wr_valid), 70'(is_write), "bus channel for command");
                if (wr_valid)
                begin
                    check(70'(wr_addr), 70'(v.addr), "wr_addr");
                    check(70'(wr_data), 70'(v.wdata), "wr_data");
                    check(70'(wr_strb), 70'(v.strb), "wr_strb");
                end
                if (rd_addr_valid)
                    check(70'(rd_addr), 70'(v.addr), "rd_addr");
                if (wr_complete)
                    comp_seen = 1'b1;
                waited++;
                @(negedge CLK);
            end
        end
        if (!finished)
        begin
            $display("Timeout: peripheral access to %h did not complete", v.addr);
            timeouts++;
        end
        else if (is_write)
        begin
            check(70'(comp_seen), 70'(1), "wr_complete before core release");
        end
        else
        begin
            check(70'(core_rdata), 70'(v.exp), "core_rdata from peripheral");
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        int exp_strobes;
        int exp_peri;
        exp_strobes = 0;
        exp_peri    = 0;
        rst_n       = 1'b0;
        run_en      = 1'b0;
        fetch_ready = 1'b1;
        ex_stalled  = 1'b0;
        core_req    = '0;
        cache_ready = 1'b1;
        cache_rdata = '0;
        rd_data     = '0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        check(70'(exit_wr_en), 70'(0), "exit_wr_en after reset");
        check(70'(rd_addr_valid), 70'(0), "rd_addr_valid after reset");
        check(70'(wr_valid), 70'(0), "wr_valid after reset");
        check(70'(rd_data_ready), 70'(0), "rd_data_ready after reset");
        check(70'(fetch_en), 70'(0), "fetch_en after reset");
        check(70'(core_ready), 70'(1), "core_ready after reset");
        rst_n = 1'b1;

        for (int i = 0; i < NUM_VEC; i++)
        begin
            exp_strobes += int'(vectors[i].exp_exit);
            if (vectors[i].addr >= `PERI_BASE && vectors[i].ctrl != `CTRL_IDLE)
            begin
                exp_peri++;
                peri_access(vectors[i]);
            end
            else
            begin
                local_access(vectors[i]);
            end
        end

        repeat (4) @(negedge CLK);
        check(70'(strobes), 70'(exp_strobes), "exit strobe count");
        check(70'(peri_beats), 70'(exp_peri), "peripheral transaction count");
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
